// ==== logic/ucode_params.svh ====
`ifndef UCODE_PARAMS_SVH
`define UCODE_PARAMS_SVH

// Microword layout
`define UC_ADDR_W       8
`define UC_WORD_W       18
`define UC_BODY_W       12
`define UC_TYPE_W       2
`define UC_BUS_W        2

// Queue depths
`define UC_DISP_DEPTH   2
`define UC_UOP_DEPTH    4

`endif

// ==== logic/ucode_field_pkg.sv ====
`include "ucode_params.svh"

package ucode_field_pkg;

// Word type, top two bits of the microword
typedef enum logic [`UC_TYPE_W-1:0] {
        MCTYPE0 = 2'd0,         // Data unit
        MCTYPE1 = 2'd1,         // Address unit
        MCTYPE2 = 2'd2          // Control
} mctype_t;

// Bus cycle, bottom two bits
typedef enum logic [`UC_BUS_W-1:0] {
        IDLE    = 2'd0,
        RD3     = 2'd1,
        WR3     = 2'd2,
        RD4     = 2'd3          // Opcode fetch, closes a routine
} bus_cycle_t;

// Type 0 data unit codes
localparam logic [3:0] T0_SRC_A     = 4'h0;
localparam logic [3:0] T0_SRC_R1    = 4'h1;
localparam logic [3:0] T0_SRC_R     = 4'h2;
localparam logic [3:0] T0_SRC_MD0   = 4'h3;
localparam logic [3:0] T0_SRC_MD    = 4'h4;
localparam logic [3:0] T0_SRC_RP1   = 4'h5;
localparam logic [3:0] T0_DST_A     = 4'h0;
localparam logic [3:0] T0_DST_R1    = 4'h1;
localparam logic [3:0] T0_DST_R     = 4'h2;
localparam logic [3:0] T0_DST_MD0   = 4'h3;
localparam logic [3:0] T0_DST_RP1   = 4'h4;
localparam logic [3:0] T0_DST_MD    = 4'h5;
localparam logic [3:0] T0_DEU_MOV   = 4'h0;
localparam logic [3:0] T0_DEU_COMOP = 4'h1;    // Operation picked by the opcode

// Type 1 address unit codes
localparam logic [3:0] T1_SRC_AAUX  = 4'h0;
localparam logic [3:0] T1_SRC_SP    = 4'h1;
localparam logic [3:0] T1_DST_MA    = 4'h0;
localparam logic [3:0] T1_DST_PC    = 4'h1;
localparam logic [3:0] T1_AEU_MOV   = 4'h0;
localparam logic [3:0] T1_AEU_PUSH  = 4'h1;    // Predecrement SP
localparam logic [3:0] T1_AEU_POP   = 4'h2;    // Postincrement SP

// Type 2 control codes
localparam logic [`UC_BODY_W-1:0] T2_NOP      = 12'h000;
localparam logic [`UC_BODY_W-1:0] T2_STA_BYTE = 12'h001;
localparam logic [`UC_BODY_W-1:0] T2_STA_WORD = 12'h002;

// Routine entry points, eight words apart
localparam logic [`UC_ADDR_W-1:0] E_MOV_R1_A = 8'h00;
localparam logic [`UC_ADDR_W-1:0] E_MOV_A_R1 = 8'h08;
localparam logic [`UC_ADDR_W-1:0] E_LDAW     = 8'h10;
localparam logic [`UC_ADDR_W-1:0] E_STAW     = 8'h18;
localparam logic [`UC_ADDR_W-1:0] E_PUSH     = 8'h20;
localparam logic [`UC_ADDR_W-1:0] E_POP      = 8'h28;
localparam logic [`UC_ADDR_W-1:0] E_JMP      = 8'h30;
localparam logic [`UC_ADDR_W-1:0] E_ALU_A_R  = 8'h38;
localparam logic [`UC_ADDR_W-1:0] E_NOP      = 8'h40;

endpackage

// ==== logic/uop_pkg.sv ====
`include "ucode_params.svh"

package uop_pkg;

// One dispatch request is just the routine entry point
typedef logic [`UC_ADDR_W-1:0] disp_req_t;

// Decoded micro-op, one per microword
typedef struct packed {
        ucode_field_pkg::mctype_t    mctype;
        logic                        flag;   // Update PSW flags
        logic                        skip;   // Skip check point
        logic [`UC_BODY_W-1:0]       body;
        ucode_field_pkg::bus_cycle_t bus;
        logic                        last;   // Set on the RD4 step
} uop_t;

endpackage

// ==== logic/uop_fifo.sv ====
`include "ucode_params.svh"

module uop_fifo #(
        parameter type payload_t = logic,
        parameter int  DEPTH     = `UC_UOP_DEPTH
) (
        input  logic     i_CLK,
        input  logic     rst_n,
        input  logic     push,
        input  payload_t push_data,
        input  logic     pop,
        output payload_t pop_data,
        output logic     empty,
        output logic     full
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

payload_t         mem [DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic             do_push;
logic             do_pop;

function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
                return '0;
        end
        return ptr + 1'b1;
endfunction

assign empty    = (count == '0);
assign full     = (count == CNT_W'(DEPTH));
assign do_push  = push && !full;       // Overflow dropped silently
assign do_pop   = pop && !empty;
assign pop_data = mem[rd_ptr];         // Show-ahead head

always_ff @(posedge i_CLK) begin
        if (do_push) begin
                mem[wr_ptr] <= push_data;
        end
end

always_ff @(posedge i_CLK or negedge rst_n) begin
        if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
        end else begin
                if (do_push) begin
                        wr_ptr <= next_ptr(wr_ptr);
                end
                if (do_pop) begin
                        rd_ptr <= next_ptr(rd_ptr);
                end
                if (do_push && !do_pop) begin
                        count <= count + 1'b1;
                end else if (do_pop && !do_push) begin
                        count <= count - 1'b1;
                end
        end
end

endmodule

// ==== logic/ucode_rom.sv ====
`include "ucode_params.svh"

module ucode_rom (
        input  logic                  i_CLK,
        input  logic                  rst_n,
        input  logic                  rd_tick,
        input  logic [`UC_ADDR_W-1:0] rd_addr,
        output uop_pkg::uop_t         uop,
        output logic                  word_valid
);

logic [`UC_WORD_W-1:0] mc;

// Word layout is type, flag, skip, body, bus
always_ff @(posedge i_CLK) begin
        if (rd_tick) begin
                case (rd_addr)
                ucode_field_pkg::E_MOV_R1_A: mc <= {ucode_field_pkg::MCTYPE0, 1'b0, 1'b1,
                        ucode_field_pkg::T0_SRC_A, ucode_field_pkg::T0_DST_R1,
                        ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::RD4};    // R1<-A
                ucode_field_pkg::E_MOV_A_R1: mc <= {ucode_field_pkg::MCTYPE0, 1'b0, 1'b1,
                        ucode_field_pkg::T0_SRC_R1, ucode_field_pkg::T0_DST_A,
                        ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::RD4};    // A<-R1
                ucode_field_pkg::E_LDAW: mc <= {ucode_field_pkg::MCTYPE2, 1'b0, 1'b0,
                        ucode_field_pkg::T2_STA_BYTE, ucode_field_pkg::RD3};   // Fetch wa byte
                ucode_field_pkg::E_LDAW + 8'd1: mc <= {ucode_field_pkg::MCTYPE1, 1'b0, 1'b1,
                        ucode_field_pkg::T1_SRC_AAUX, ucode_field_pkg::T1_DST_MA,
                        ucode_field_pkg::T1_AEU_MOV, ucode_field_pkg::RD3};    // MA<-V.wa
                ucode_field_pkg::E_LDAW + 8'd2: mc <= {ucode_field_pkg::MCTYPE0, 1'b0, 1'b0,
                        ucode_field_pkg::T0_SRC_MD0, ucode_field_pkg::T0_DST_A,
                        ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::RD4};    // A<-MD0
                ucode_field_pkg::E_STAW: mc <= {ucode_field_pkg::MCTYPE2, 1'b0, 1'b0,
                        ucode_field_pkg::T2_STA_BYTE, ucode_field_pkg::RD3};
                ucode_field_pkg::E_STAW + 8'd1: mc <= {ucode_field_pkg::MCTYPE1, 1'b0, 1'b1,
                        ucode_field_pkg::T1_SRC_AAUX, ucode_field_pkg::T1_DST_MA,
                        ucode_field_pkg::T1_AEU_MOV, ucode_field_pkg::WR3};    // Write cycle
                ucode_field_pkg::E_STAW + 8'd2: mc <= {ucode_field_pkg::MCTYPE0, 1'b0, 1'b0,
                        ucode_field_pkg::T0_SRC_A, ucode_field_pkg::T0_DST_MD0,
                        ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::RD4};    // MD0<-A
                ucode_field_pkg::E_PUSH: mc <= {ucode_field_pkg::MCTYPE0, 1'b0, 1'b1,
                        ucode_field_pkg::T0_SRC_RP1, ucode_field_pkg::T0_DST_MD,
                        ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::IDLE};   // MD<-rp1
                ucode_field_pkg::E_PUSH + 8'd1: mc <= {ucode_field_pkg::MCTYPE1, 1'b0, 1'b0,
                        ucode_field_pkg::T1_SRC_SP, ucode_field_pkg::T1_DST_MA,
                        ucode_field_pkg::T1_AEU_PUSH, ucode_field_pkg::WR3};   // High byte
                ucode_field_pkg::E_PUSH + 8'd2: mc <= {ucode_field_pkg::MCTYPE2, 1'b0, 1'b0,
                        ucode_field_pkg::T2_NOP, ucode_field_pkg::WR3};        // Low byte
                ucode_field_pkg::E_PUSH + 8'd3: mc <= {ucode_field_pkg::MCTYPE2, 1'b0, 1'b0,
                        ucode_field_pkg::T2_NOP, ucode_field_pkg::RD4};
                ucode_field_pkg::E_POP: mc <= {ucode_field_pkg::MCTYPE1, 1'b0, 1'b1,
                        ucode_field_pkg::T1_SRC_SP, ucode_field_pkg::T1_DST_MA,
                        ucode_field_pkg::T1_AEU_POP, ucode_field_pkg::RD3};
                ucode_field_pkg::E_POP + 8'd1: mc <= {ucode_field_pkg::MCTYPE2, 1'b0, 1'b0,
                        ucode_field_pkg::T2_NOP, ucode_field_pkg::RD3};
                ucode_field_pkg::E_POP + 8'd2: mc <= {ucode_field_pkg::MCTYPE0, 1'b0, 1'b0,
                        ucode_field_pkg::T0_SRC_MD, ucode_field_pkg::T0_DST_RP1,
                        ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::RD4};    // rp1<-MD
                ucode_field_pkg::E_JMP: mc <= {ucode_field_pkg::MCTYPE2, 1'b0, 1'b0,
                        ucode_field_pkg::T2_NOP, ucode_field_pkg::RD3};
                ucode_field_pkg::E_JMP + 8'd1: mc <= {ucode_field_pkg::MCTYPE2, 1'b0, 1'b0,
                        ucode_field_pkg::T2_STA_WORD, ucode_field_pkg::RD3};   // Target word
                ucode_field_pkg::E_JMP + 8'd2: mc <= {ucode_field_pkg::MCTYPE1, 1'b0, 1'b1,
                        ucode_field_pkg::T1_SRC_AAUX, ucode_field_pkg::T1_DST_PC,
                        ucode_field_pkg::T1_AEU_MOV, ucode_field_pkg::RD4};    // PC<-AAUX
                ucode_field_pkg::E_ALU_A_R: mc <= {ucode_field_pkg::MCTYPE0, 1'b1, 1'b1,
                        ucode_field_pkg::T0_SRC_R, ucode_field_pkg::T0_DST_A,
                        ucode_field_pkg::T0_DEU_COMOP, ucode_field_pkg::RD4};  // A<-A op r
                ucode_field_pkg::E_NOP: mc <= {ucode_field_pkg::MCTYPE2, 1'b0, 1'b1,
                        ucode_field_pkg::T2_NOP, ucode_field_pkg::RD4};
                default: mc <= {ucode_field_pkg::MCTYPE2, 1'b0, 1'b1,
                        ucode_field_pkg::T2_NOP, ucode_field_pkg::RD4};        // Unknown entry
                endcase
        end
end

always_ff @(posedge i_CLK or negedge rst_n) begin
        if (!rst_n) begin
                word_valid <= 1'b0;
        end else begin
                word_valid <= rd_tick;
        end
end

assign uop.mctype = ucode_field_pkg::mctype_t'(mc[`UC_WORD_W-1 -: `UC_TYPE_W]);
assign uop.flag   = mc[`UC_WORD_W-`UC_TYPE_W-1];
assign uop.skip   = mc[`UC_WORD_W-`UC_TYPE_W-2];
assign uop.body   = mc[`UC_BUS_W +: `UC_BODY_W];
assign uop.bus    = ucode_field_pkg::bus_cycle_t'(mc[`UC_BUS_W-1:0]);
assign uop.last   = (uop.bus == ucode_field_pkg::RD4);   // Fetch of next opcode

endmodule

// ==== logic/ucode_sequencer.sv ====
`include "ucode_params.svh"

module ucode_sequencer (
        input  logic                  i_CLK,
        input  logic                  rst_n,
        input  logic                  req_valid,
        input  uop_pkg::disp_req_t    req_addr,
        output logic                  req_pop,
        input  logic                  word_valid,
        input  logic                  word_last,
        input  logic                  out_full,
        output logic                  rd_tick,
        output logic [`UC_ADDR_W-1:0] rd_addr
);

typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
} seq_state_t;

seq_state_t            state;
logic [`UC_ADDR_W-1:0] upc;     // Micro program counter

assign req_pop = (state == S_IDLE) && req_valid;
assign rd_tick = (state == S_ISSUE) && !out_full;   // Room for the returning word
assign rd_addr = upc;

always_ff @(posedge i_CLK or negedge rst_n) begin
        if (!rst_n) begin
                state <= S_IDLE;
                upc   <= '0;
        end else begin
                case (state)
                S_IDLE: begin
                        if (req_pop) begin
                                upc   <= req_addr;
                                state <= S_ISSUE;
                        end
                end
                S_ISSUE: begin
                        if (rd_tick) begin
                                state <= S_WAIT;
                        end
                end
                S_WAIT: begin
                        // ROM answers one clock after the tick
                        if (word_valid) begin
                                if (word_last) begin
                                        state <= S_IDLE;
                                end else begin
                                        upc   <= upc + 1'b1;
                                        state <= S_ISSUE;
                                end
                        end
                end
                default: begin
                        state <= S_IDLE;
                end
                endcase
        end
end

endmodule

// ==== logic/ucode_engine.sv ====
`include "ucode_params.svh"

module ucode_engine (
        input  logic                        i_CLK,
        input  logic                        rst_n,
        input  logic                        disp_valid,
        input  uop_pkg::disp_req_t          disp_addr,
        output logic                        disp_ready,
        output logic                        uop_valid,
        output ucode_field_pkg::mctype_t    uop_type,
        output logic                        uop_flag,
        output logic                        uop_skip,
        output logic [`UC_BODY_W-1:0]       uop_body,
        output ucode_field_pkg::bus_cycle_t uop_bus,
        output logic                        uop_last,
        input  logic                        uop_ready
);

logic                  disp_empty;
logic                  disp_full;
uop_pkg::disp_req_t    req_addr;
logic                  req_pop;
logic                  rd_tick;
logic [`UC_ADDR_W-1:0] rd_addr;
uop_pkg::uop_t         rom_uop;
logic                  word_valid;
logic                  uop_empty;
logic                  uop_full;
uop_pkg::uop_t         q_uop;

assign disp_ready = !disp_full;
assign uop_valid  = !uop_empty;

uop_fifo #(
        .payload_t (uop_pkg::disp_req_t),
        .DEPTH     (`UC_DISP_DEPTH)
) disp_q (
        .i_CLK     (i_CLK),
        .rst_n     (rst_n),
        .push      (disp_valid),
        .push_data (disp_addr),
        .pop       (req_pop),
        .pop_data  (req_addr),
        .empty     (disp_empty),
        .full      (disp_full)
);

ucode_sequencer u_seq (
        .i_CLK      (i_CLK),
        .rst_n      (rst_n),
        .req_valid  (!disp_empty),
        .req_addr   (req_addr),
        .req_pop    (req_pop),
        .word_valid (word_valid),
        .word_last  (rom_uop.last),
        .out_full   (uop_full),
        .rd_tick    (rd_tick),
        .rd_addr    (rd_addr)
);

ucode_rom u_rom (
        .i_CLK      (i_CLK),
        .rst_n      (rst_n),
        .rd_tick    (rd_tick),
        .rd_addr    (rd_addr),
        .uop        (rom_uop),
        .word_valid (word_valid)
);

uop_fifo #(
        .payload_t (uop_pkg::uop_t),
        .DEPTH     (`UC_UOP_DEPTH)
) uop_q (
        .i_CLK     (i_CLK),
        .rst_n     (rst_n),
        .push      (word_valid),
        .push_data (rom_uop),
        .pop       (uop_ready),
        .pop_data  (q_uop),
        .empty     (uop_empty),
        .full      (uop_full)
);

// Head of the micro-op queue onto the loose ports
assign uop_type = q_uop.mctype;
assign uop_flag = q_uop.flag;
assign uop_skip = q_uop.skip;
assign uop_body = q_uop.body;
assign uop_bus  = q_uop.bus;
assign uop_last = q_uop.last;

endmodule

// ==== tb/ucode_checker.sv ====
`include "ucode_params.svh"

module ucode_checker #(
        parameter int N_ROWS  = 1,
        parameter int N_STEPS = 1
) (
        input  logic                  i_CLK,
        input  logic                  rst_n,
        input  logic                  disp_valid,
        input  logic [`UC_ADDR_W-1:0] disp_addr,
        input  logic                  disp_ready,
        input  logic                  uop_valid,
        input  logic [`UC_WORD_W-1:0] uop_word,
        input  logic                  uop_last,
        input  logic                  uop_ready,
        input  logic [`UC_ADDR_W-1:0] row_addr [N_ROWS],
        input  int                    row_first [N_ROWS],
        input  int                    row_len [N_ROWS],
        input  logic [`UC_WORD_W-1:0] step_word [N_STEPS],
        input  logic                  random_phase,
        input  logic                  end_of_test,
        output int                    received,
        output int                    mismatches,
        output int                    failures,
        output logic                  report_done
);

logic [`UC_ADDR_W+`UC_WORD_W:0] exp_q [$];     // Routine address, word, last
logic [`UC_WORD_W:0]            seen;
logic [`UC_WORD_W:0]            held;           // Head seen during a stall
logic                           held_valid = 1'b0;
logic                           first_edge_done = 1'b0;
logic                           saw_stall = 1'b0;
int                             n_received = 0;
int                             n_mismatch = 0;
int                             n_fail = 0;

initial begin
        received    = 0;
        mismatches  = 0;
        failures    = 0;
        report_done = 1'b0;
end

task automatic queue_routine(input logic [`UC_ADDR_W-1:0] addr);
        int r;
        r = -1;
        for (int i = 0; i < N_ROWS; i++) begin
                if (row_addr[i] == addr) begin
                        r = i;
                end
        end
        if (r < 0) begin
                n_fail++;
                $display("dispatched address 0x%h has no row in the stimulus table", addr);
        end else begin
                for (int s = 0; s < row_len[r]; s++) begin
                        exp_q.push_back({addr, step_word[row_first[r] + s], s == row_len[r] - 1});
                end
        end
endtask

always @(posedge i_CLK) begin
        seen = {uop_word, uop_last};
        if (!rst_n) begin
                first_edge_done = 1'b0;
                held_valid      = 1'b0;
        end else begin
                if (!first_edge_done) begin
                        if (uop_valid || !disp_ready) begin
                                n_mismatch++;
                                $display("error %0t: after reset uop_valid=%b disp_ready=%b",
                                        $time, uop_valid, disp_ready);
                        end
                        first_edge_done = 1'b1;
                end
                if (random_phase && !disp_ready) begin
                        saw_stall = 1'b1;
                end
                if (held_valid && (!uop_valid || seen != held)) begin
                        n_mismatch++;
                        $display("error %0t: head changed during stall, %h became %h valid %b",
                                $time, held, seen, uop_valid);
                end
                if (disp_valid && disp_ready) begin
                        queue_routine(disp_addr);
                end
                if (uop_valid && uop_ready) begin
                        if (exp_q.size() == 0) begin
                                n_fail++;
                                $display("micro-op %h arrived when none was expected", seen);
                        end else begin
                                if (seen != exp_q[0][`UC_WORD_W:0]) begin
                                        n_mismatch++;
                                        $display("error %0t: routine 0x%h gave %h/%b, want %h/%b",
                                                $time, exp_q[0][`UC_ADDR_W+`UC_WORD_W -: `UC_ADDR_W],
                                                uop_word, uop_last,
                                                exp_q[0][`UC_WORD_W:1], exp_q[0][0]);
                                end
                                void'(exp_q.pop_front());
                        end
                        n_received++;
                end
                held_valid = uop_valid && !uop_ready;
                held       = seen;
                if (end_of_test && !report_done) begin
                        if (exp_q.size() != 0) begin
                                n_fail++;
                                $display("%0d expected micro-ops never arrived", exp_q.size());
                        end
                        if (!saw_stall) begin
                                n_fail++;
                                $display("disp_ready never went low while uop_ready was random");
                        end
                        report_done <= 1'b1;
                end
        end
        received   <= n_received;      // Seen by the tb one edge later
        mismatches <= n_mismatch;
        failures   <= n_fail;
end

endmodule

// ==== tb/ucode_engine_tb.sv ====
`include "ucode_params.svh"

module ucode_engine_tb;

localparam int N_ROWS     = 11;
localparam int N_STEPS    = 22;
localparam int TOTAL      = 2 * N_STEPS;      // Table goes out twice
localparam int MAX_CYCLES = 20 * TOTAL + 100;

logic                        i_CLK;
logic                        rst_n;
logic                        disp_valid;
logic [`UC_ADDR_W-1:0]       disp_addr;
logic                        disp_ready;
logic                        uop_valid;
ucode_field_pkg::mctype_t    uop_type;
logic                        uop_flag;
logic                        uop_skip;
logic [`UC_BODY_W-1:0]       uop_body;
ucode_field_pkg::bus_cycle_t uop_bus;
logic                        uop_last;
logic                        uop_ready;

logic [`UC_ADDR_W-1:0] row_addr [N_ROWS];
int                    row_first [N_ROWS];
int                    row_len [N_ROWS];
logic [`UC_WORD_W-1:0] step_word [N_STEPS];
int                    n_rows = 0;
int                    n_steps = 0;
logic                  random_ready;
logic                  end_of_test;
int                    received;
int                    mismatches;
int                    failures;
logic                  report_done;
int                    cycles = 0;

ucode_engine dut (
        .i_CLK      (i_CLK),
        .rst_n      (rst_n),
        .disp_valid (disp_valid),
        .disp_addr  (disp_addr),
        .disp_ready (disp_ready),
        .uop_valid  (uop_valid),
        .uop_type   (uop_type),
        .uop_flag   (uop_flag),
        .uop_skip   (uop_skip),
        .uop_body   (uop_body),
        .uop_bus    (uop_bus),
        .uop_last   (uop_last),
        .uop_ready  (uop_ready)
);

ucode_checker #(
        .N_ROWS  (N_ROWS),
        .N_STEPS (N_STEPS)
) chk (
        .i_CLK        (i_CLK),
        .rst_n        (rst_n),
        .disp_valid   (disp_valid),
        .disp_addr    (disp_addr),
        .disp_ready   (disp_ready),
        .uop_valid    (uop_valid),
        .uop_word     ({uop_type, uop_flag, uop_skip, uop_body, uop_bus}),
        .uop_last     (uop_last),
        .uop_ready    (uop_ready),
        .row_addr     (row_addr),
        .row_first    (row_first),
        .row_len      (row_len),
        .step_word    (step_word),
        .random_phase (random_ready),
        .end_of_test  (end_of_test),
        .received     (received),
        .mismatches   (mismatches),
        .failures     (failures),
        .report_done  (report_done)
);

// Data or address unit step, body is source, destination, operation
function automatic logic [`UC_WORD_W-1:0] op_step(input ucode_field_pkg::mctype_t t,
        input logic flag, input logic skip, input logic [3:0] src, input logic [3:0] dst,
        input logic [3:0] op, input ucode_field_pkg::bus_cycle_t bus);
        return {t, flag, skip, src, dst, op, bus};
endfunction

function automatic logic [`UC_WORD_W-1:0] ctrl_step(input logic flag, input logic skip,
        input logic [`UC_BODY_W-1:0] code, input ucode_field_pkg::bus_cycle_t bus);
        return {ucode_field_pkg::MCTYPE2, flag, skip, code, bus};
endfunction

task automatic add_row(input logic [`UC_ADDR_W-1:0] addr, input int len);
        row_addr[n_rows]  = addr;
        row_first[n_rows] = n_steps;
        row_len[n_rows]   = len;
        n_rows++;
endtask

task automatic add_step(input logic [`UC_WORD_W-1:0] w);
        step_word[n_steps] = w;
        n_steps++;
endtask

task automatic build_table();
        add_row(ucode_field_pkg::E_MOV_R1_A, 1);
        add_step(op_step(ucode_field_pkg::MCTYPE0, 1'b0, 1'b1, ucode_field_pkg::T0_SRC_A,
                ucode_field_pkg::T0_DST_R1, ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::RD4));
        add_row(ucode_field_pkg::E_MOV_A_R1, 1);
        add_step(op_step(ucode_field_pkg::MCTYPE0, 1'b0, 1'b1, ucode_field_pkg::T0_SRC_R1,
                ucode_field_pkg::T0_DST_A, ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::RD4));
        add_row(ucode_field_pkg::E_LDAW, 3);
        add_step(ctrl_step(1'b0, 1'b0, ucode_field_pkg::T2_STA_BYTE, ucode_field_pkg::RD3));
        add_step(op_step(ucode_field_pkg::MCTYPE1, 1'b0, 1'b1, ucode_field_pkg::T1_SRC_AAUX,
                ucode_field_pkg::T1_DST_MA, ucode_field_pkg::T1_AEU_MOV, ucode_field_pkg::RD3));
        add_step(op_step(ucode_field_pkg::MCTYPE0, 1'b0, 1'b0, ucode_field_pkg::T0_SRC_MD0,
                ucode_field_pkg::T0_DST_A, ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::RD4));
        add_row(ucode_field_pkg::E_STAW, 3);
        add_step(ctrl_step(1'b0, 1'b0, ucode_field_pkg::T2_STA_BYTE, ucode_field_pkg::RD3));
        add_step(op_step(ucode_field_pkg::MCTYPE1, 1'b0, 1'b1, ucode_field_pkg::T1_SRC_AAUX,
                ucode_field_pkg::T1_DST_MA, ucode_field_pkg::T1_AEU_MOV, ucode_field_pkg::WR3));
        add_step(op_step(ucode_field_pkg::MCTYPE0, 1'b0, 1'b0, ucode_field_pkg::T0_SRC_A,
                ucode_field_pkg::T0_DST_MD0, ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::RD4));
        add_row(ucode_field_pkg::E_PUSH, 4);
        add_step(op_step(ucode_field_pkg::MCTYPE0, 1'b0, 1'b1, ucode_field_pkg::T0_SRC_RP1,
                ucode_field_pkg::T0_DST_MD, ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::IDLE));
        add_step(op_step(ucode_field_pkg::MCTYPE1, 1'b0, 1'b0, ucode_field_pkg::T1_SRC_SP,
                ucode_field_pkg::T1_DST_MA, ucode_field_pkg::T1_AEU_PUSH, ucode_field_pkg::WR3));
        add_step(ctrl_step(1'b0, 1'b0, ucode_field_pkg::T2_NOP, ucode_field_pkg::WR3));
        add_step(ctrl_step(1'b0, 1'b0, ucode_field_pkg::T2_NOP, ucode_field_pkg::RD4));
        add_row(ucode_field_pkg::E_POP, 3);
        add_step(op_step(ucode_field_pkg::MCTYPE1, 1'b0, 1'b1, ucode_field_pkg::T1_SRC_SP,
                ucode_field_pkg::T1_DST_MA, ucode_field_pkg::T1_AEU_POP, ucode_field_pkg::RD3));
        add_step(ctrl_step(1'b0, 1'b0, ucode_field_pkg::T2_NOP, ucode_field_pkg::RD3));
        add_step(op_step(ucode_field_pkg::MCTYPE0, 1'b0, 1'b0, ucode_field_pkg::T0_SRC_MD,
                ucode_field_pkg::T0_DST_RP1, ucode_field_pkg::T0_DEU_MOV, ucode_field_pkg::RD4));
        add_row(ucode_field_pkg::E_JMP, 3);
        add_step(ctrl_step(1'b0, 1'b0, ucode_field_pkg::T2_NOP, ucode_field_pkg::RD3));
        add_step(ctrl_step(1'b0, 1'b0, ucode_field_pkg::T2_STA_WORD, ucode_field_pkg::RD3));
        add_step(op_step(ucode_field_pkg::MCTYPE1, 1'b0, 1'b1, ucode_field_pkg::T1_SRC_AAUX,
                ucode_field_pkg::T1_DST_PC, ucode_field_pkg::T1_AEU_MOV, ucode_field_pkg::RD4));
        add_row(ucode_field_pkg::E_ALU_A_R, 1);
        add_step(op_step(ucode_field_pkg::MCTYPE0, 1'b1, 1'b1, ucode_field_pkg::T0_SRC_R,
                ucode_field_pkg::T0_DST_A, ucode_field_pkg::T0_DEU_COMOP, ucode_field_pkg::RD4));
        add_row(ucode_field_pkg::E_NOP, 1);
        add_step(ctrl_step(1'b0, 1'b1, ucode_field_pkg::T2_NOP, ucode_field_pkg::RD4));
        add_row(8'h41, 1);          // Not an entry point
        add_step(ctrl_step(1'b0, 1'b1, ucode_field_pkg::T2_NOP, ucode_field_pkg::RD4));
        add_row(8'ha7, 1);
        add_step(ctrl_step(1'b0, 1'b1, ucode_field_pkg::T2_NOP, ucode_field_pkg::RD4));
endtask

// Hold one request until the edge that accepts it
task automatic send_row(input int r);
        disp_valid <= 1'b1;
        disp_addr  <= row_addr[r];
        @(posedge i_CLK);
        while (!disp_ready) begin
                @(posedge i_CLK);
        end
endtask

initial begin
        i_CLK = 1'b0;
        forever begin
                #20 i_CLK = ~i_CLK;
        end
end

// Sink ready pattern
initial begin
        void'($urandom(32'h3d31a5a5));
        forever begin
                @(posedge i_CLK);
                if (random_ready) begin
                        uop_ready <= ($urandom() % 32'd2) == 32'd1;     // About half the edges
                end else begin
                        uop_ready <= 1'b1;
                end
        end
end

always @(posedge i_CLK) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
                $display("timeout after %0d cycles, %0d of %0d micro-ops arrived",
                        cycles, received, TOTAL);
                $display("errors: %0d wrong values, %0d other failures, run timed out",
                        mismatches, failures);
                $display("TEST FAILED");
                $finish;
        end
end

initial begin
        rst_n        = 1'b0;
        disp_valid   = 1'b0;
        disp_addr    = '0;
        uop_ready    = 1'b1;
        random_ready = 1'b0;
        end_of_test  = 1'b0;
        build_table();
        repeat (3) @(posedge i_CLK);
        rst_n <= 1'b1;
        @(posedge i_CLK);
        // First pass with the sink always ready, second with random stalls
        for (int pass = 0; pass < 2; pass++) begin
                random_ready <= (pass == 1);
                for (int r = 0; r < N_ROWS; r++) begin
                        send_row(r);
                end
                disp_valid <= 1'b0;
                while (received < (pass + 1) * N_STEPS) begin
                        @(posedge i_CLK);
                end
        end
        end_of_test <= 1'b1;
        while (!report_done) begin
                @(posedge i_CLK);
        end
        $display("errors: %0d wrong values, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
                $display("TEST OK");
        end else begin
                $display("TEST FAILED");
        end
        $finish;
end

endmodule

// ==== ucode_engine.f ====
+incdir+logic
logic/ucode_field_pkg.sv
logic/uop_pkg.sv
logic/uop_fifo.sv
logic/ucode_rom.sv
logic/ucode_sequencer.sv
logic/ucode_engine.sv
tb/ucode_checker.sv
tb/ucode_engine_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --timing
TOP       = ucode_engine_tb
FILELIST  = ucode_engine.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
